// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

   // ******************************
   // Widths and enums
   // ******************************
   localparam int DCCM_AW_MAX = 16;   // Widest DCCM word address

   typedef enum logic {
      LSU_LOAD,
      LSU_STORE
   } lsu_op_e;

   typedef enum logic [1:0] {
      SZ_BYTE,
      SZ_HALF,
      SZ_WORD
   } lsu_size_e;

   typedef enum logic [1:0] {
      ERR_NONE,
      ERR_MISALIGN,
      ERR_ECC,        // Uncorrectable DCCM data
      ERR_BUS         // External slave error
   } lsu_err_e;

   typedef enum logic [1:0] {
      S_IDLE,
      S_DCCM,
      S_BUS,
      S_RESP          // Response held until req drops
   } ctl_state_e;

   // ******************************
   // Request, response and ports
   // ******************************
   typedef struct packed {
      lsu_op_e            op;
      lsu_size_e          size;
      logic               is_unsigned;  // Zero-extend loaded data
      logic [31:0]        rs1;          // Base register
      logic signed [11:0] offset;
      logic [31:0]        wdata;        // Store data, low aligned
   } lsu_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      lsu_err_e    err;
   } lsu_rsp_t;

   typedef struct packed {
      logic [31:0] data;
      logic [6:0]  check;   // Bit 6 is overall parity
   } ecc_word_t;

   typedef struct packed {
      logic                   rden;
      logic                   wren;
      logic [DCCM_AW_MAX-1:0] addr;   // Word address
      ecc_word_t              wdata;
   } dccm_cmd_t;

   typedef struct packed {
      logic        we;
      logic [31:0] addr;      // Byte address
      logic [3:0]  byte_en;
      logic [31:0] wdata;
   } ext_cmd_t;

endpackage

// ==== hw/lsu_ecc.sv ====
`timescale 1ns/1ps

module lsu_ecc (
   input  logic [31:0]        enc_data,
   output lsu_pkg::ecc_word_t enc_word,
   input  lsu_pkg::ecc_word_t dec_word,
   output logic [31:0]        dec_data,
   output logic               dec_single,   // Corrected single-bit error
   output logic               dec_double    // Uncorrectable
);

   logic [5:0]  enc_chk;
   logic [38:1] dec_cw;    // Received word in Hamming positions
   logic [38:1] cor_cw;
   logic [5:0]  syn;
   logic        par_err;   // Overall parity mismatch

   // Check bits sit at powers of two, data fills the other positions
   function automatic logic [38:1] spread(input logic [31:0] d, input logic [5:0] c);
      logic [38:1] cw;
      int          k;
      int          j;
      k = 0;
      j = 0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) == 0) begin
            cw[p] = c[j];
            j++;
         end else begin
            cw[p] = d[k];
            k++;
         end
      end
      return cw;
   endfunction

   function automatic logic [31:0] gather(input logic [38:1] cw);
      logic [31:0] d;
      int          k;
      k = 0;
      d = '0;
      for (int p = 1; p <= 38; p++) begin
         if ((p & (p - 1)) != 0) begin
            d[k] = cw[p];
            k++;
         end
      end
      return d;
   endfunction

   // Bit i covers every position with bit i set
   function automatic logic [5:0] syndrome(input logic [38:1] cw);
      logic [5:0] s;
      s = '0;
      for (int p = 1; p <= 38; p++) begin
         for (int i = 0; i < 6; i++) begin
            if (p[i]) s[i] ^= cw[p];
         end
      end
      return s;
   endfunction

   // ******************************
   // Encoder
   // ******************************
   assign enc_chk        = syndrome(spread(enc_data, 6'b0));
   assign enc_word.data  = enc_data;
   assign enc_word.check = {^{enc_data, enc_chk}, enc_chk};   // Even overall parity

   // ******************************
   // Decoder
   // ******************************
   assign dec_cw  = spread(dec_word.data, dec_word.check[5:0]);
   assign syn     = syndrome(dec_cw);
   assign par_err = ^{dec_word.data, dec_word.check};

   always_comb begin
      cor_cw = dec_cw;
      for (int p = 1; p <= 38; p++) begin
         if (par_err && syn == 6'(p)) cor_cw[p] = ~dec_cw[p];   // Syndrome points at the bad bit
      end
   end

   assign dec_data   = gather(cor_cw);
   assign dec_single = par_err && (syn <= 6'd38);   // Zero syndrome means the parity bit itself
   assign dec_double = (!par_err && syn != 6'd0) || (par_err && syn > 6'd38);

endmodule

// ==== hw/lsu_lane_align.sv ====
`timescale 1ns/1ps

module lsu_lane_align (
   input  lsu_pkg::lsu_size_e size,
   input  logic               is_unsigned,
   input  logic [1:0]         off,
   input  logic [31:0]        wdata,
   output logic [31:0]        st_data,
   output logic [3:0]         st_be,
   input  logic [31:0]        ld_word,
   output logic [31:0]        ld_value
);
   import lsu_pkg::*;

   logic [31:0] ld_shift;   // Addressed lane moved to bit 0

   // Store lanes, replicated so any offset finds its byte
   always_comb begin
      unique case (size)
         SZ_BYTE: begin
            st_data = {4{wdata[7:0]}};
            st_be   = 4'b0001 << off;
         end
         SZ_HALF: begin
            st_data = {2{wdata[15:0]}};
            st_be   = 4'b0011 << off;
         end
         default: begin
            st_data = wdata;
            st_be   = 4'b1111;
         end
      endcase
   end

   assign ld_shift = ld_word >> {off, 3'b000};

   always_comb begin
      unique case (size)
         SZ_BYTE: ld_value = {{24{!is_unsigned && ld_shift[7]}}, ld_shift[7:0]};
         SZ_HALF: ld_value = {{16{!is_unsigned && ld_shift[15]}}, ld_shift[15:0]};
         default: ld_value = ld_word;
      endcase
   end

endmodule

// ==== hw/lsu_bus_master.sv ====
`timescale 1ns/1ps

module lsu_bus_master (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  lsu_pkg::ext_cmd_t cmd,
   output logic              done,
   output logic [31:0]       rword,
   output logic              err,
   output logic              ext_req,
   output lsu_pkg::ext_cmd_t ext_cmd,   // Stable while ext_req is high
   input  logic              ext_ack,
   input  logic [31:0]       ext_rdata,
   input  logic              ext_err
);

   typedef enum logic [1:0] {
      B_IDLE,
      B_REQ,     // req high, waiting for ack
      B_DROP     // req low, waiting for ack to fall
   } bus_state_e;

   bus_state_e state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= B_IDLE;
         ext_req <= 1'b0;
      end else begin
         unique case (state)
            B_IDLE: begin
               if (start) begin
                  ext_req <= 1'b1;
                  state   <= B_REQ;
               end
            end
            B_REQ: begin
               if (ext_ack) begin
                  ext_req <= 1'b0;
                  state   <= B_DROP;
               end
            end
            B_DROP: if (!ext_ack) state <= B_IDLE;
            default: state <= B_IDLE;
         endcase
      end
   end

   // Command and returned data
   always_ff @(posedge clk) begin
      if (state == B_IDLE && start) ext_cmd <= cmd;
      if (state == B_REQ && ext_ack) begin
         rword <= ext_rdata;
         err   <= ext_err;
      end
   end

   assign done = (state == B_DROP) && !ext_ack;   // Handshake fully closed

endmodule

// ==== hw/lsu_dccm_port.sv ====
`timescale 1ns/1ps

module lsu_dccm_port #(
   parameter int DCCM_AW = 10
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               start,
   input  lsu_pkg::lsu_op_e   op,
   input  logic [DCCM_AW-1:0] addr,
   input  logic [31:0]        wdata,     // Lane-aligned store data
   input  logic [3:0]         byte_en,
   output logic               done,
   output logic [31:0]        rword,     // Corrected read word
   output logic               dbl_err,
   output lsu_pkg::dccm_cmd_t dccm_cmd,
   input  lsu_pkg::ecc_word_t dccm_rdata,
   output logic               single_err
);
   import lsu_pkg::*;

   typedef enum logic [1:0] {
      P_IDLE,
      P_RD,      // Read strobe on the port
      P_CHK,     // Read data back, decode
      P_WR       // Write strobe on the port
   } port_state_e;

   port_state_e state;
   lsu_op_e     op_q;
   logic [31:0] wdata_q;
   logic [3:0]  be_q;
   logic [31:0] merged;     // Corrected word with new bytes laid in
   logic [31:0] enc_data;
   ecc_word_t   enc_word;
   logic [31:0] dec_data;
   logic        dec_single;
   logic        dec_double;

   lsu_ecc u_ecc (
      .enc_data   (enc_data),
      .enc_word   (enc_word),
      .dec_word   (dccm_rdata),
      .dec_data   (dec_data),
      .dec_single (dec_single),
      .dec_double (dec_double)
   );

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = be_q[b] ? wdata_q[8*b +: 8] : dec_data[8*b +: 8];
      end
   end

   // Full words encode straight from the input, RMW from the merge
   assign enc_data = (state == P_IDLE) ? wdata : merged;

   always_ff @(posedge clk) begin
      if (state == P_IDLE && start) begin
         op_q    <= op;
         wdata_q <= wdata;
         be_q    <= byte_en;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= P_IDLE;
         dccm_cmd <= '0;
      end else begin
         unique case (state)
            P_IDLE: begin
               if (start) begin
                  dccm_cmd.addr <= DCCM_AW_MAX'(addr);
                  if (op == LSU_STORE && byte_en == 4'hf) begin
                     dccm_cmd.wren  <= 1'b1;      // Word store, no read needed
                     dccm_cmd.wdata <= enc_word;
                     state          <= P_WR;
                  end else begin
                     dccm_cmd.rden <= 1'b1;       // Load or first half of RMW
                     state         <= P_RD;
                  end
               end
            end
            P_RD: begin
               dccm_cmd.rden <= 1'b0;
               state         <= P_CHK;
            end
            P_CHK: begin
               if (op_q == LSU_STORE && !dec_double) begin
                  dccm_cmd.wren  <= 1'b1;
                  dccm_cmd.wdata <= enc_word;
                  state          <= P_WR;
               end else begin
                  state <= P_IDLE;                // Load done, or RMW aborted
               end
            end
            P_WR: begin
               dccm_cmd.wren <= 1'b0;
               state         <= P_IDLE;
            end
            default: state <= P_IDLE;
         endcase
      end
   end

   assign done       = (state == P_WR) ||
                       (state == P_CHK && (op_q == LSU_LOAD || dec_double));
   assign rword      = dec_data;
   assign dbl_err    = (state == P_CHK) && dec_double;
   assign single_err = (state == P_CHK) && dec_single;   // One pulse per corrected read

endmodule

// ==== hw/lsu_ctl.sv ====
`timescale 1ns/1ps

module lsu_ctl #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter int          DCCM_AW   = 10
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   input  lsu_pkg::lsu_req_t  req_data,
   output logic               ack,
   output lsu_pkg::lsu_rsp_t  rsp,
   output lsu_pkg::lsu_req_t  a_req,      // Latched request
   output logic [1:0]         a_off,      // Byte offset within the word
   output logic [31:0]        ld_word,    // Raw returned word to the aligner
   input  logic [31:0]        ld_value,
   input  logic [31:0]        st_data,
   input  logic [3:0]         st_be,
   output logic               dccm_start,
   output lsu_pkg::lsu_op_e   dccm_op,
   output logic [DCCM_AW-1:0] dccm_addr,
   input  logic               dccm_done,
   input  logic [31:0]        dccm_rword,
   input  logic               dccm_dbl_err,
   output logic               bus_start,
   output lsu_pkg::ext_cmd_t  bus_cmd,
   input  logic               bus_done,
   input  logic [31:0]        bus_rword,
   input  logic               bus_err
);
   import lsu_pkg::*;

   localparam int RGN_LSB = DCCM_AW + 2;   // First address bit above the DCCM span

   ctl_state_e  state;
   logic [31:0] eff_addr;   // From the incoming request
   logic [31:0] a_addr;     // Latched effective address
   logic        misalign;
   logic        in_dccm;
   logic        launch;     // First cycle in S_DCCM or S_BUS
   logic        is_load;

   // ******************************
   // Address and decode
   // ******************************
   assign eff_addr = req_data.rs1 + {{20{req_data.offset[11]}}, req_data.offset};

   // Natural alignment only, bytes never fault
   assign misalign = (req_data.size == SZ_HALF && eff_addr[0]) ||
                     (req_data.size == SZ_WORD && eff_addr[1:0] != 2'b00);

   assign in_dccm = (eff_addr[31:RGN_LSB] == DCCM_BASE[31:RGN_LSB]);

   // Request fields stay put for the whole access
   always_ff @(posedge clk) begin
      if (state == S_IDLE && req) begin
         a_req  <= req_data;
         a_addr <= eff_addr;
      end
   end

   assign is_load = (a_req.op == LSU_LOAD);
   assign a_off   = a_addr[1:0];

   // ******************************
   // Sequencer
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         ack    <= 1'b0;
         launch <= 1'b0;
         rsp    <= '0;
      end else begin
         launch <= 1'b0;   // Single-cycle start
         unique case (state)
            S_IDLE: begin
               if (req) begin
                  if (misalign) begin   // No memory traffic at all
                     rsp   <= '{rdata: '0, err: ERR_MISALIGN};
                     state <= S_RESP;
                  end else begin
                     launch <= 1'b1;
                     state  <= in_dccm ? S_DCCM : S_BUS;
                  end
               end
            end
            S_DCCM: begin
               if (dccm_done) begin
                  rsp.rdata <= (is_load && !dccm_dbl_err) ? ld_value : '0;
                  rsp.err   <= dccm_dbl_err ? ERR_ECC : ERR_NONE;
                  ack       <= 1'b1;
                  state     <= S_RESP;
               end
            end
            S_BUS: begin
               if (bus_done) begin   // Waits here on a slow slave
                  rsp.rdata <= (is_load && !bus_err) ? ld_value : '0;
                  rsp.err   <= bus_err ? ERR_BUS : ERR_NONE;
                  ack       <= 1'b1;
                  state     <= S_RESP;
               end
            end
            S_RESP: begin
               if (!ack) begin
                  ack <= 1'b1;          // Misaligned path arrives without ack
               end else if (!req) begin
                  ack   <= 1'b0;        // Fourth phase
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // ******************************
   // Datapath hookup
   // ******************************
   assign dccm_start = launch && (state == S_DCCM);
   assign bus_start  = launch && (state == S_BUS);
   assign dccm_op    = a_req.op;
   assign dccm_addr  = a_addr[RGN_LSB-1:2];

   assign bus_cmd = '{we: !is_load, addr: a_addr, byte_en: st_be, wdata: st_data};

   assign ld_word = (state == S_BUS) ? bus_rword : dccm_rword;   // Returned word select

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
   parameter logic [31:0] DCCM_BASE = 32'hF004_0000,
   parameter int          DCCM_AW   = 10             // 4 KiB of DCCM
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   input  lsu_pkg::lsu_req_t  req_data,
   output logic               ack,
   output lsu_pkg::lsu_rsp_t  rsp,
   output lsu_pkg::dccm_cmd_t dccm_cmd,
   input  lsu_pkg::ecc_word_t dccm_rdata,
   output logic               ext_req,
   output lsu_pkg::ext_cmd_t  ext_cmd,
   input  logic               ext_ack,
   input  logic [31:0]        ext_rdata,
   input  logic               ext_err,
   output logic               ecc_single_err
);
   import lsu_pkg::*;

   lsu_req_t           a_req;
   logic [1:0]         a_off;
   logic [31:0]        ld_word;
   logic [31:0]        ld_value;
   logic [31:0]        st_data;
   logic [3:0]         st_be;
   logic               dccm_start;
   lsu_op_e            dccm_op;
   logic [DCCM_AW-1:0] dccm_addr;
   logic               dccm_done;
   logic [31:0]        dccm_rword;
   logic               dccm_dbl_err;
   logic               bus_start;
   ext_cmd_t           bus_cmd;
   logic               bus_done;
   logic [31:0]        bus_rword;
   logic               bus_err;

   // ******************************
   // Controller
   // ******************************
   lsu_ctl #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_AW   (DCCM_AW)
   ) u_ctl (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .req_data     (req_data),
      .ack          (ack),
      .rsp          (rsp),
      .a_req        (a_req),
      .a_off        (a_off),
      .ld_word      (ld_word),
      .ld_value     (ld_value),
      .st_data      (st_data),
      .st_be        (st_be),
      .dccm_start   (dccm_start),
      .dccm_op      (dccm_op),
      .dccm_addr    (dccm_addr),
      .dccm_done    (dccm_done),
      .dccm_rword   (dccm_rword),
      .dccm_dbl_err (dccm_dbl_err),
      .bus_start    (bus_start),
      .bus_cmd      (bus_cmd),
      .bus_done     (bus_done),
      .bus_rword    (bus_rword),
      .bus_err      (bus_err)
   );

   // ******************************
   // Datapath
   // ******************************
   lsu_dccm_port #(
      .DCCM_AW (DCCM_AW)
   ) u_dccm (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (dccm_start),
      .op         (dccm_op),
      .addr       (dccm_addr),
      .wdata      (st_data),     // Same lanes as the bus
      .byte_en    (st_be),
      .done       (dccm_done),
      .rword      (dccm_rword),
      .dbl_err    (dccm_dbl_err),
      .dccm_cmd   (dccm_cmd),
      .dccm_rdata (dccm_rdata),
      .single_err (ecc_single_err)
   );

   lsu_bus_master u_bus (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (bus_start),
      .cmd       (bus_cmd),
      .done      (bus_done),
      .rword     (bus_rword),
      .err       (bus_err),
      .ext_req   (ext_req),
      .ext_cmd   (ext_cmd),
      .ext_ack   (ext_ack),
      .ext_rdata (ext_rdata),
      .ext_err   (ext_err)
   );

   lsu_lane_align u_align (
      .size        (a_req.size),
      .is_unsigned (a_req.is_unsigned),
      .off         (a_off),
      .wdata       (a_req.wdata),
      .st_data     (st_data),
      .st_be       (st_be),
      .ld_word     (ld_word),
      .ld_value    (ld_value)
   );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int HALF_NS    = 20,   // 40 ns period
   parameter int RST_CYCLES = 10
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_NS) clk = ~clk;
   end

   // Reset low for a fixed number of edges, released on an edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;
   import lsu_pkg::*;

   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;
   localparam int          DCCM_AW   = 10;
   localparam logic [31:0] EXT_BASE  = 32'h0000_2000;
   localparam logic [31:0] ERR_PAGE  = 32'h0000_F000;   // Slave answers with an error here
   localparam int          N_WORDS   = 32;              // Words touched per region
   localparam int          N_TESTS   = 200;
   localparam int          TIMEOUT   = 200;             // Cycles per handshake phase

   typedef enum logic [1:0] {
      X_IDLE,
      X_WAIT,    // Counting down the response delay
      X_ACK      // Ack high until req drops
   } slave_state_e;

   logic         clk;
   logic         rst_n;
   logic         req;
   lsu_req_t     req_data;
   logic         ack;
   lsu_rsp_t     rsp;
   dccm_cmd_t    dccm_cmd;
   ecc_word_t    dccm_rdata = '0;
   logic         ext_req;
   ext_cmd_t     ext_cmd;
   logic         ext_ack    = 1'b0;
   logic [31:0]  ext_rdata  = '0;
   logic         ext_err    = 1'b0;
   logic         ecc_single_err;

   ecc_word_t    dccm_mem [2**DCCM_AW];
   logic [31:0]  dshadow [2**DCCM_AW];       // Reference DCCM contents
   logic [31:0]  ext_mem [logic [31:0]];     // Slave side memory
   logic [31:0]  xshadow [logic [31:0]];     // Reference external contents
   logic [31:0]  x_wa;                       // Word the slave is addressing
   logic [38:0]  inj_mask;                   // Bits flipped on DCCM reads
   int           ext_delay;
   int           ext_cnt;
   slave_state_e x_state = X_IDLE;
   ext_cmd_t     ext_seen;                   // Last command the slave took
   int           n_single = 0;
   int           n_ext    = 0;
   int           n_rd     = 0;
   int           n_wr     = 0;
   integer       seed     = 32'ha498_e0cd;
   int           n_pass;
   int           n_fail;
   bit           timed_out;

   tb_clk_gen u_clk (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lsu_top #(
      .DCCM_BASE (DCCM_BASE),
      .DCCM_AW   (DCCM_AW)
   ) dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .req            (req),
      .req_data       (req_data),
      .ack            (ack),
      .rsp            (rsp),
      .dccm_cmd       (dccm_cmd),
      .dccm_rdata     (dccm_rdata),
      .ext_req        (ext_req),
      .ext_cmd        (ext_cmd),
      .ext_ack        (ext_ack),
      .ext_rdata      (ext_rdata),
      .ext_err        (ext_err),
      .ecc_single_err (ecc_single_err)
   );

   // ******************************
   // Helpers and reference rules
   // ******************************
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return ~{a[31:2], 2'b00};   // Untouched external words read as the inverted address
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] be);
      logic [31:0] m;
      for (int b = 0; b < 4; b++) begin
         m[8*b +: 8] = be[b] ? nw[8*b +: 8] : old[8*b +: 8];
      end
      return m;
   endfunction

   function automatic logic [3:0] lane_mask(input lsu_size_e sz, input logic [1:0] off);
      case (sz)
         SZ_BYTE: return 4'b0001 << off;
         SZ_HALF: return 4'b0011 << off;
         default: return 4'hf;
      endcase
   endfunction

   function automatic logic [31:0] extend_load(input logic [31:0] w, input lsu_size_e sz,
                                               input logic uns, input logic [1:0] off);
      logic [31:0] s;
      s = w >> (8 * int'(off));   // Addressed lane down to bit 0
      case (sz)
         SZ_BYTE: return uns ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
         SZ_HALF: return uns ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
         default: return w;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act, inout int fails);
      assert (act === exp) else begin
         $display("** Error %s: expected %h actual %h", name, exp, act);
         fails++;
      end
   endtask

   // ******************************
   // DCCM and external models
   // ******************************
   always @(posedge clk) begin
      if (dccm_cmd.wren) dccm_mem[dccm_cmd.addr[DCCM_AW-1:0]] <= dccm_cmd.wdata;
      if (dccm_cmd.rden) dccm_rdata <= dccm_mem[dccm_cmd.addr[DCCM_AW-1:0]] ^ inj_mask;
      if (ecc_single_err) n_single <= n_single + 1;
      if (dccm_cmd.rden) n_rd <= n_rd + 1;   // Strobes last one cycle each
      if (dccm_cmd.wren) n_wr <= n_wr + 1;
   end

   assign x_wa = {ext_cmd.addr[31:2], 2'b00};   // Slave memory holds whole words

   always @(posedge clk) begin
      if (!rst_n) begin
         x_state <= X_IDLE;
         ext_ack <= 1'b0;
      end else begin
         case (x_state)
            X_IDLE: if (ext_req) begin
               ext_seen <= ext_cmd;
               ext_cnt  <= ext_delay;
               n_ext    <= n_ext + 1;
               x_state  <= X_WAIT;
            end
            X_WAIT: if (ext_cnt != 0) begin
               ext_cnt <= ext_cnt - 1;
            end else begin
               ext_ack   <= 1'b1;
               ext_err   <= (ext_cmd.addr[31:12] == ERR_PAGE[31:12]);
               ext_rdata <= ext_mem.exists(x_wa) ? ext_mem[x_wa] : fill_word(x_wa);
               if (ext_cmd.we && ext_cmd.addr[31:12] != ERR_PAGE[31:12]) begin
                  ext_mem[x_wa] = merge_bytes(
                     ext_mem.exists(x_wa) ? ext_mem[x_wa] : fill_word(x_wa),
                     ext_cmd.wdata, ext_cmd.byte_en);
               end
               x_state <= X_ACK;
            end
            default: if (!ext_req) begin   // Fourth phase
               ext_ack <= 1'b0;
               x_state <= X_IDLE;
            end
         endcase
      end
   end

   // ******************************
   // Stimulus
   // ******************************
   task automatic pick_request(input int t, output lsu_req_t r, output logic [38:0] mask,
                               output logic [31:0] a);
      int          rgn;
      int          idx;
      int          bit_a;
      int          kind;
      logic [11:0] off12;
      r.op          = (($random(seed) & 1) != 0) ? LSU_STORE : LSU_LOAD;
      r.is_unsigned = (($random(seed) & 1) != 0);
      r.wdata       = $random(seed);
      case ($unsigned($random(seed)) % 3)
         0:       r.size = SZ_BYTE;
         1:       r.size = SZ_HALF;
         default: r.size = SZ_WORD;
      endcase
      rgn  = $unsigned($random(seed)) % 10;   // 0..5 DCCM, 6..8 bus, 9 error page
      idx  = $unsigned($random(seed)) % N_WORDS;
      a    = (rgn < 6) ? DCCM_BASE : (rgn < 9) ? EXT_BASE : ERR_PAGE;
      a    = a + 32'(4 * idx) + 32'($unsigned($random(seed)) % 4);
      mask = '0;
      if (t < N_WORDS) begin   // Fill the DCCM words with full stores first
         r.op   = LSU_STORE;
         r.size = SZ_WORD;
         a      = DCCM_BASE + 32'(4 * t);
      end else begin
         if ($unsigned($random(seed)) % 8 != 0) begin   // Mostly aligned
            if (r.size == SZ_HALF) a[0] = 1'b0;
            if (r.size == SZ_WORD) a[1:0] = 2'b00;
         end
         kind  = $unsigned($random(seed)) % 10;
         bit_a = $unsigned($random(seed)) % 39;
         if (kind < 2) mask = 39'd1 << bit_a;
         if (kind == 2) mask = (39'd1 << bit_a) |
                               (39'd1 << ((bit_a + 1 + $unsigned($random(seed)) % 38) % 39));
      end
      off12    = 12'($random(seed));
      r.offset = off12;
      r.rs1    = a - {{20{off12[11]}}, off12};   // Base chosen to land on a
   endtask

   // Full four-phase exchange with ok left low on a timeout
   task automatic run_access(input lsu_req_t r, input logic [38:0] mask, input int delay,
                             output lsu_rsp_t got, output bit ok);
      int cyc;
      ok  = 1'b0;
      got = '0;
      @(posedge clk);
      req       <= 1'b1;
      req_data  <= r;
      inj_mask  <= mask;
      ext_delay <= delay;
      cyc = 0;
      do begin
         @(posedge clk);
         cyc++;
      end while (!ack && cyc < TIMEOUT);
      if (!ack) begin
         $display("Timeout: ack never rose for the request");
      end else begin
         got = rsp;
         req <= 1'b0;
         cyc = 0;
         do begin
            @(posedge clk);
            cyc++;
         end while (ack && cyc < TIMEOUT);
         if (ack) $display("Timeout: ack stayed high after req dropped");
         else ok = 1'b1;
      end
   endtask

   // ******************************
   // Test sequence
   // ******************************
   initial begin
      lsu_req_t    r;
      lsu_rsp_t    got;
      lsu_rsp_t    exp;
      logic [38:0] mask;
      logic [31:0] a;
      logic [31:0] wa;
      logic [31:0] word;
      logic [3:0]  be;
      string       tag;
      int          fails;
      int          cyc;
      int          idx;
      int          s0;
      int          x0;
      int          rd0;
      int          wr0;
      bit          ok;
      bit          mis;
      bit          in_dccm;
      bit          st;
      bit          reads;
      bit          dbl;
      bit          sgl;
      bit          ep;
      req       = 1'b0;
      req_data  = '0;
      inj_mask  = '0;
      ext_delay = 0;
      n_pass    = 0;
      n_fail    = 0;
      timed_out = 1'b0;
      cyc       = 0;
      while (!rst_n && cyc < TIMEOUT) begin
         @(posedge clk);
         cyc++;
      end
      @(posedge clk);
      fails = 0;
      check_value("reset_state", 32'h0,
                  {28'h0, ack, ext_req, dccm_cmd.rden, dccm_cmd.wren}, fails);
      assert (rst_n) else begin
         $display("Reset never released");
         fails++;
      end
      if (fails == 0) n_pass++;
      else n_fail++;
      $display("%-24s %s", "reset_state", (fails == 0) ? "pass" : "FAIL");

      for (int t = 0; t < N_TESTS && !timed_out; t++) begin
         pick_request(t, r, mask, a);
         mis     = (r.size == SZ_HALF && a[0]) || (r.size == SZ_WORD && a[1:0] != 2'b00);
         in_dccm = (a[31:12] == DCCM_BASE[31:12]);   // 4 KiB window
         st      = (r.op == LSU_STORE);
         be      = lane_mask(r.size, a[1:0]);
         reads   = !mis && in_dccm && (!st || be != 4'hf);   // Loads and RMW read first
         dbl     = reads && ($countones(mask) == 2);
         sgl     = reads && ($countones(mask) == 1);
         ep      = (a[31:12] == ERR_PAGE[31:12]);
         idx     = int'(a[11:2]);
         wa      = {a[31:2], 2'b00};
         exp     = '{rdata: '0, err: ERR_NONE};
         // Predict the response and update the shadows
         if (mis) begin
            exp.err = ERR_MISALIGN;
         end else if (in_dccm) begin
            if (dbl) exp.err = ERR_ECC;
            else if (st) dshadow[idx] = merge_bytes(dshadow[idx], r.wdata << (8 * a[1:0]), be);
            else exp.rdata = extend_load(dshadow[idx], r.size, r.is_unsigned, a[1:0]);
         end else begin
            word = xshadow.exists(wa) ? xshadow[wa] : fill_word(wa);
            if (ep) exp.err = ERR_BUS;
            else if (st) xshadow[wa] = merge_bytes(word, r.wdata << (8 * a[1:0]), be);
            else exp.rdata = extend_load(word, r.size, r.is_unsigned, a[1:0]);
         end
         tag = $sformatf("t%0d %s %s @%h", t, st ? "st" : "ld", r.size.name(), a);
         s0  = n_single;
         x0  = n_ext;
         rd0 = n_rd;
         wr0 = n_wr;
         run_access(r, mask, $unsigned($random(seed)) % 6, got, ok);
         fails = 0;
         if (!ok) begin
            timed_out = 1'b1;
            fails++;
         end else begin
            check_value({tag, " rdata"}, exp.rdata, got.rdata, fails);
            check_value({tag, " err"}, 32'(exp.err), 32'(got.err), fails);
            check_value({tag, " ecc pulses"}, sgl ? 1 : 0, n_single - s0, fails);
            check_value({tag, " ext reqs"}, (!mis && !in_dccm) ? 1 : 0, n_ext - x0, fails);
            if (mis || !in_dccm) begin   // No DCCM traffic outside its window
               check_value({tag, " dccm rd"}, 0, n_rd - rd0, fails);
               check_value({tag, " dccm wr"}, 0, n_wr - wr0, fails);
            end
            if (!mis && in_dccm && st) begin
               check_value({tag, " dccm word"}, dshadow[idx], dccm_mem[idx].data, fails);
            end
            if (!mis && !in_dccm) begin
               check_value({tag, " ext addr"}, a, ext_seen.addr, fails);
               check_value({tag, " ext be"}, 32'(be), 32'(ext_seen.byte_en), fails);
               check_value({tag, " ext we"}, 32'(st), 32'(ext_seen.we), fails);
            end
         end
         if (fails == 0) n_pass++;
         else n_fail++;
         $display("%-24s %s", tag, (fails == 0) ? "pass" : "FAIL");
      end

      $display("Tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0 && !timed_out) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
hw/lsu_pkg.sv
hw/lsu_ecc.sv
hw/lsu_lane_align.sv
hw/lsu_bus_master.sv
hw/lsu_dccm_port.sv
hw/lsu_ctl.sv
hw/lsu_top.sv
sim/tb_clk_gen.sv
sim/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the LSU testbench

OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --assert -j 0 --top-module lsu_tb -Mdir $(OBJ_DIR) -f filelist.f

run: compile
	@out="$$(./$(OBJ_DIR)/Vlsu_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
